/* sim.f */
+incdir+.
fpu_types_pkg.sv
float_add.sv
float_classify.sv
fpu_top.sv
tb_fpu_top.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_fpu_top -f sim.f -o tb_fpu_top_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_fpu_top_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "All tests passed"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* tb_fpu_util.svh */
`ifndef TB_FPU_UTIL_SVH
`define TB_FPU_UTIL_SVH

// cycles to wait for a result strobe
localparam int RESULT_TIMEOUT = 10;
// x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

localparam fpu_flags_t NO_FLAGS = '{invalid: 1'b0, overflow: 1'b0, zero: 1'b0};
localparam fpu_flags_t INVALID_FLAG = '{invalid: 1'b1, overflow: 1'b0, zero: 1'b0};
localparam fpu_flags_t OVERFLOW_FLAG = '{invalid: 1'b0, overflow: 1'b1, zero: 1'b0};
localparam fpu_flags_t ZERO_FLAG = '{invalid: 1'b0, overflow: 1'b0, zero: 1'b1};

// galois form, one step per bit
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
	if (state[0])
	begin
		return (state >> 1) ^ LFSR_TAPS;
	end
	else
	begin
		return state >> 1;
	end
endfunction

function automatic logic [15:0] take_random_bits(input int count);
	logic [15:0] bits;
	bits = '0;
	for (int i = 0; i < count; i++)
	begin
		lfsr_state = lfsr_step(lfsr_state);
		bits = {bits[14:0], lfsr_state[0]};
	end
	return bits;
endfunction

function automatic half_float_t random_finite();
	half_float_t value;
	value = take_random_bits(16);
	// all-ones exponent would be inf or NaN
	if (value.exponent == '1)
	begin
		value.exponent = 5'h1e;
	end
	return value;
endfunction

function automatic fpu_rounding_mode_t random_mode();
	logic [15:0] bits;
	bits = take_random_bits(2);
	return fpu_rounding_mode_t'(bits[1:0]);
endfunction

task automatic compare_float(input string what, input half_float_t got,
	input half_float_t expected);
	if (got !== expected)
	begin
		report_failure($sformatf("Fail at %0t: %s gave value %h, expected %h",
			$time, what, got, expected));
	end
endtask

task automatic compare_flags(input string what, input fpu_flags_t got,
	input fpu_flags_t expected);
	if (got !== expected)
	begin
		report_failure($sformatf("Fail at %0t: %s gave flags %b, expected %b",
			$time, what, got, expected));
	end
endtask

// one request, then poll the result strobe on falling edges
task automatic run_request(input half_float_t a, input half_float_t b, input fpu_op_t op,
	input fpu_rounding_mode_t mode, output fpu_result_t result);
	int cycles;
	@(posedge clk);
	req_valid <= 1'b1;
	req <= '{a: a, b: b, op: op, rounding_mode: mode};
	@(posedge clk);
	req_valid <= 1'b0;
	@(negedge clk);
	cycles = 1;
	while (!res_valid)
	begin
		if (cycles >= RESULT_TIMEOUT)
		begin
			report_failure($sformatf("timeout: no result arrived within %0d cycles",
				RESULT_TIMEOUT));
		end
		@(negedge clk);
		cycles++;
	end
	if (cycles != 2)
	begin
		report_failure($sformatf("Fail at %0t: result arrived after %0d cycles, expected 2",
			$time, cycles));
	end
	result = res;
endtask

`endif

/* tb_fpu_top.sv */
`timescale 1ns/1ps

`include "fpu_defines.svh"

module tb_fpu_top
	import fpu_types_pkg::*;
();

logic clk;
logic rst;
logic req_valid;
fpu_req_t req;
logic res_valid;
fpu_result_t res;
logic [31:0] lfsr_state;

task automatic report_failure(input string msg);
	$display("%s", msg);
	$display("Some tests failed");
	$fatal(1, "simulation stopped at the first error");
endtask

`include "tb_fpu_util.svh"

task automatic check_op(input half_float_t a, input half_float_t b, input fpu_op_t op,
	input fpu_rounding_mode_t mode, input half_float_t exp_value, input fpu_flags_t exp_flags);
	fpu_result_t result;
	string what;
	what = $sformatf("%h %s %h in %s", a, op.name(), b, mode.name());
	run_request(a, b, op, mode, result);
	compare_float(what, result.value, exp_value);
	compare_flags(what, result.flags, exp_flags);
endtask

// expected results in nearest-even, up, down, toward zero
task automatic check_round(input half_float_t a, input half_float_t b, input fpu_op_t op,
	input half_float_t rne, input half_float_t ru, input half_float_t rd, input half_float_t rz);
	check_op(a, b, op, ROUND_NEAREST_EVEN, rne, NO_FLAGS);
	check_op(a, b, op, ROUND_INF, ru, NO_FLAGS);
	check_op(a, b, op, ROUND_INFN, rd, NO_FLAGS);
	check_op(a, b, op, ROUND_ZERO, rz, NO_FLAGS);
endtask

task automatic test_exact_add();
	fpu_rounding_mode_t mode;
	for (int m = 0; m < 4; m++)
	begin
		mode = fpu_rounding_mode_t'(m[1:0]);
		check_op(16'h3c00, 16'h3c00, OP_ADD, mode, 16'h4000, NO_FLAGS);
		check_op(16'h3e00, 16'h3400, OP_ADD, mode, 16'h3f00, NO_FLAGS);
		check_op(16'h4000, 16'h3800, OP_SUB, mode, 16'h3e00, NO_FLAGS);
		// two subnormals reach the smallest normal
		check_op(16'h0200, 16'h0200, OP_ADD, mode, 16'h0400, NO_FLAGS);
	end
endtask

task automatic test_rounding();
	// 2048 + 1, a tie with an even lower neighbour
	check_round(16'h6800, 16'h3c00, OP_ADD, 16'h6800, 16'h6801, 16'h6800, 16'h6800);
	// 2048 + 3, a tie with an even upper neighbour
	check_round(16'h6800, 16'h4200, OP_ADD, 16'h6802, 16'h6802, 16'h6801, 16'h6801);
	// 2048 + 1.25, just above the tie
	check_round(16'h6800, 16'h3d00, OP_ADD, 16'h6801, 16'h6801, 16'h6800, 16'h6800);
	// -2048 - 3, directed modes swap for a negative sum
	check_round(16'he800, 16'hc200, OP_ADD, 16'he802, 16'he801, 16'he802, 16'he801);
	// 2048 - 0.75 drops into the binade below
	check_round(16'h6800, 16'h3a00, OP_SUB, 16'h67ff, 16'h6800, 16'h67ff, 16'h67ff);
endtask

task automatic test_specials();
	check_op(`FLOAT_QNAN, 16'h3c00, OP_ADD, ROUND_NEAREST_EVEN, `FLOAT_QNAN, INVALID_FLAG);
	check_op(16'h3c00, 16'h7c01, OP_ADD, ROUND_NEAREST_EVEN, `FLOAT_QNAN, INVALID_FLAG);
	check_op(16'hfe00, 16'h3c00, OP_NEG_ADD, ROUND_ZERO, `FLOAT_QNAN, INVALID_FLAG);
	check_op(`FLOAT_POS_INF, `FLOAT_NEG_INF, OP_ADD, ROUND_NEAREST_EVEN, `FLOAT_QNAN,
		INVALID_FLAG);
	check_op(`FLOAT_POS_INF, `FLOAT_POS_INF, OP_SUB, ROUND_INF, `FLOAT_QNAN, INVALID_FLAG);
	check_op(`FLOAT_POS_INF, 16'h3c00, OP_ADD, ROUND_NEAREST_EVEN, `FLOAT_POS_INF, NO_FLAGS);
	check_op(16'h3c00, `FLOAT_NEG_INF, OP_ADD, ROUND_ZERO, `FLOAT_NEG_INF, NO_FLAGS);
	// largest finite value doubled
	check_op(16'h7bff, 16'h7bff, OP_ADD, ROUND_NEAREST_EVEN, `FLOAT_POS_INF, OVERFLOW_FLAG);
	check_op(16'h7bff, 16'h7bff, OP_ADD, ROUND_ZERO, 16'h7bff, OVERFLOW_FLAG);
	check_op(16'h7bff, 16'h7bff, OP_ADD, ROUND_INFN, 16'h7bff, OVERFLOW_FLAG);
	check_op(16'hfbff, 16'hfbff, OP_ADD, ROUND_INF, 16'hfbff, OVERFLOW_FLAG);
	check_op(16'hfbff, 16'hfbff, OP_ADD, ROUND_INFN, `FLOAT_NEG_INF, OVERFLOW_FLAG);
endtask

task automatic test_cancel_random();
	half_float_t x;
	half_float_t cancel_zero;
	half_float_t plus_zero;
	fpu_rounding_mode_t mode;
	repeat (200)
	begin
		x = random_finite();
		mode = random_mode();
		cancel_zero = (mode == ROUND_INFN) ? `FLOAT_NEG_ZERO : `FLOAT_POS_ZERO;
		// -0 + +0 is itself an exact cancellation
		plus_zero = (x == `FLOAT_NEG_ZERO) ? cancel_zero : x;
		check_op(x, `FLOAT_POS_ZERO, OP_ADD, mode, plus_zero,
			({x.exponent, x.fraction} == '0) ? ZERO_FLAG : NO_FLAGS);
		check_op(x, x, OP_SUB, mode, cancel_zero, ZERO_FLAG);
	end
endtask

task automatic test_negate_and_order();
	half_float_t a;
	half_float_t b;
	half_float_t expected_neg;
	fpu_rounding_mode_t mode;
	fpu_result_t sum_ab;
	fpu_result_t neg_ab;
	fpu_result_t sum_ba;
	string what;
	repeat (100)
	begin
		a = random_finite();
		b = random_finite();
		mode = random_mode();
		what = $sformatf("%h and %h in %s", a, b, mode.name());
		run_request(a, b, OP_ADD, mode, sum_ab);
		run_request(a, b, OP_NEG_ADD, mode, neg_ab);
		run_request(b, a, OP_ADD, mode, sum_ba);
		expected_neg = sum_ab.value;
		if (!((expected_neg.exponent == '1) && (expected_neg.fraction != '0)))
		begin
			expected_neg.sign = ~expected_neg.sign;
		end
		compare_float({"negate-add of ", what}, neg_ab.value, expected_neg);
		compare_flags({"negate-add of ", what}, neg_ab.flags, sum_ab.flags);
		compare_float({"swapped add of ", what}, sum_ba.value, sum_ab.value);
		compare_flags({"swapped add of ", what}, sum_ba.flags, sum_ab.flags);
	end
endtask

task automatic test_back_to_back();
	half_float_t a_list [4];
	half_float_t b_list [4];
	fpu_op_t op_list [4];
	half_float_t exp_list [4];
	int issued;
	int received;
	int waited;
	a_list = '{16'h3c00, 16'h3e00, 16'h4000, 16'h0200};
	b_list = '{16'h3c00, 16'h3400, 16'h3800, 16'h0200};
	op_list = '{OP_ADD, OP_ADD, OP_SUB, OP_ADD};
	exp_list = '{16'h4000, 16'h3f00, 16'h3e00, 16'h0400};
	issued = 0;
	received = 0;
	waited = 0;
	while (received < 4)
	begin
		@(posedge clk);
		if (issued < 4)
		begin
			req_valid <= 1'b1;
			req <= '{a: a_list[issued], b: b_list[issued], op: op_list[issued],
				rounding_mode: ROUND_NEAREST_EVEN};
			issued++;
		end
		else
		begin
			req_valid <= 1'b0;
		end
		@(negedge clk);
		if (res_valid)
		begin
			compare_float($sformatf("burst result %0d", received), res.value,
				exp_list[received]);
			compare_flags($sformatf("burst result %0d", received), res.flags, NO_FLAGS);
			received++;
		end
		else if (received > 0)
		begin
			report_failure("burst results did not arrive on consecutive cycles");
		end
		waited++;
		if (waited > RESULT_TIMEOUT + 4)
		begin
			report_failure("timeout: not all burst results arrived");
		end
	end
endtask

initial
begin
	clk = 1'b0;
	forever
	begin
		#10 clk = ~clk;
	end
end

fpu_top dut_i
(
	.clk(clk),
	.rst(rst),
	.req_valid(req_valid),
	.req(req),
	.res_valid(res_valid),
	.res(res)
);

initial
begin
	rst = 1'b1;
	req_valid = 1'b0;
	req = '0;
	lfsr_state = 32'h7df4;
	repeat (16) @(posedge clk);
	rst <= 1'b0;
	@(negedge clk);
	if (res_valid)
	begin
		report_failure("result strobe was high right after reset");
	end
	compare_float("reset state", res.value, `FLOAT_POS_ZERO);
	compare_flags("reset state", res.flags, NO_FLAGS);
	test_exact_add();
	test_rounding();
	test_specials();
	test_cancel_random();
	test_negate_and_order();
	test_back_to_back();
	$display("All tests passed");
	$finish;
end

endmodule

/* fpu_top.sv */
`timescale 1ns/1ps

`include "fpu_defines.svh"

module fpu_top
	import fpu_types_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req_valid,
	input fpu_req_t req,
	output logic res_valid,
	output fpu_result_t res
);

// stage 1 operand registers
logic s1_valid;
half_float_t s1_a;
half_float_t s1_b;
fpu_rounding_mode_t s1_mode;
logic s1_negate;

// combinational results between the stages
half_float_t add_sum;
logic add_overflow;
fpu_flags_t add_flags;
logic sum_is_nan;
half_float_t result_value;

always_ff @(posedge clk)
begin
	if (rst)
	begin
		s1_valid <= 1'b0;
	end
	else
	begin
		s1_valid <= req_valid;
	end
end

// subtract is an add with b negated up front
always_ff @(posedge clk)
begin
	if (req_valid)
	begin
		s1_a <= req.a;
		s1_b <= '{sign: req.b.sign ^ (req.op == OP_SUB),
			exponent: req.b.exponent,
			fraction: req.b.fraction};
		s1_mode <= req.rounding_mode;
		s1_negate <= (req.op == OP_NEG_ADD);
	end
end

float_add add_i
(
	.a(s1_a),
	.b(s1_b),
	.rounding_mode(s1_mode),
	.sum(add_sum),
	.overflow(add_overflow)
);

float_classify classify_i
(
	.a(s1_a),
	.b(s1_b),
	.sum(add_sum),
	.overflow(add_overflow),
	.flags(add_flags)
);

// negate-add flips the sign of anything but a NaN
assign sum_is_nan = (add_sum.exponent == '1) & (add_sum.fraction != '0);

always_comb
begin
	result_value = add_sum;
	if (s1_negate && !sum_is_nan)
	begin
		result_value[`SIGN_POS] = ~add_sum.sign;
	end
end

// stage 2 result registers
always_ff @(posedge clk)
begin
	if (rst)
	begin
		res_valid <= 1'b0;
		res.value <= `FLOAT_POS_ZERO;
		res.flags <= '0;
	end
	else
	begin
		res_valid <= s1_valid;
		if (s1_valid)
		begin
			res.value <= result_value;
			res.flags <= add_flags;
		end
	end
end

// fixed two cycle latency through both stages
assert property (@(posedge clk) disable iff (rst) req_valid |-> ##2 res_valid)
else $error("result strobe missing two cycles after request");

assert property (@(posedge clk) disable iff (rst) res_valid |-> $past(req_valid, 2))
else $error("result strobe without a request two cycles earlier");

endmodule

/* float_classify.sv */
`timescale 1ns/1ps

module float_classify
	import fpu_types_pkg::*;
(
	input half_float_t a,
	input half_float_t b,
	input half_float_t sum,
	input logic overflow,
	output fpu_flags_t flags
);

logic a_nan, b_nan, a_inf, b_inf;
logic both_finite;
logic sum_inf, sum_zero;

// a NaN has an all-ones exponent and a nonzero fraction
assign a_nan = (a.exponent == '1) & (a.fraction != '0);
assign b_nan = (b.exponent == '1) & (b.fraction != '0);
assign a_inf = (a.exponent == '1) & (a.fraction == '0);
assign b_inf = (b.exponent == '1) & (b.fraction == '0);
assign both_finite = (a.exponent != '1) & (b.exponent != '1);

assign sum_inf = (sum.exponent == '1) & (sum.fraction == '0);
assign sum_zero = (sum.exponent == '0) & (sum.fraction == '0);

always_comb
begin
	// b arrives with the opcode sign already applied
	flags.invalid = a_nan | b_nan | (a_inf & b_inf & (a.sign != b.sign));
	// either a real infinity or a clamp to the largest finite value
	flags.overflow = both_finite & (overflow | sum_inf);
	flags.zero = sum_zero;
end

// a NaN result can never also read as zero
always_comb
begin
	if (!$isunknown(flags))
	begin
		assert (!(flags.invalid && flags.zero))
		else $error("invalid and zero flags set together");
	end
end

endmodule

/* float_add.sv */
`timescale 1ns/1ps

`include "fpu_defines.svh"

module float_add
	import fpu_types_pkg::*;
(
	input half_float_t a,
	input half_float_t b,
	input fpu_rounding_mode_t rounding_mode,
	output half_float_t sum,
	output logic overflow
);

// significand plus guard, round, sticky
localparam int EXT_W = `MANT_W + `GRS_W;
// any larger shift leaves nothing but sticky
localparam int SHIFT_CAP = EXT_W + 1;

logic a_nan, b_nan, a_inf, b_inf;
logic a_larger;
half_float_t big, small_op;
logic [`EXP_W - 1 : 0] big_exp_eff, small_exp_eff, exp_diff;
logic [3:0] shift_amt;
logic [EXT_W + SHIFT_CAP - 1 : 0] shift_vec;
logic [EXT_W - 1 : 0] big_ext, small_ext, small_aligned;
logic eff_sub;
logic [EXT_W : 0] raw;
logic [EXT_W - 1 : 0] norm;
logic [`EXP_W : 0] exp_norm;
logic [3:0] lz;
logic [`EXP_W - 1 : 0] shift_limit;
logic [3:0] left_shift;
logic inexact, round_up, clamp;
logic [`FLOAT_W - 1 : 0] rounded;
logic range_ovf;

// operand classes
assign a_nan = (a.exponent == '1) & (a.fraction != '0);
assign b_nan = (b.exponent == '1) & (b.fraction != '0);
assign a_inf = (a.exponent == '1) & (a.fraction == '0);
assign b_inf = (b.exponent == '1) & (b.fraction == '0);

// order by magnitude so that big >= small_op
assign a_larger = {a.exponent, a.fraction} >= {b.exponent, b.fraction};
assign big = a_larger ? a : b;
assign small_op = a_larger ? b : a;
assign eff_sub = big.sign ^ small_op.sign;

// subnormals share the exponent of the smallest normal
assign big_exp_eff = (big.exponent == '0) ? `EXP_W'(1) : big.exponent;
assign small_exp_eff = (small_op.exponent == '0) ? `EXP_W'(1) : small_op.exponent;
assign exp_diff = big_exp_eff - small_exp_eff;

assign big_ext = {big.exponent != '0, big.fraction, {`GRS_W{1'b0}}};
assign small_ext = {small_op.exponent != '0, small_op.fraction, {`GRS_W{1'b0}}};

// alignment folds everything shifted out into the sticky bit
assign shift_amt = (exp_diff > `EXP_W'(SHIFT_CAP)) ? 4'(SHIFT_CAP) : exp_diff[3:0];
assign shift_vec = {small_ext, {SHIFT_CAP{1'b0}}} >> shift_amt;
assign small_aligned = {shift_vec[EXT_W + SHIFT_CAP - 1 : SHIFT_CAP + 1],
	shift_vec[SHIFT_CAP] | (|shift_vec[SHIFT_CAP - 1 : 0])};

// magnitude add or subtract with big never smaller than small_op
assign raw = eff_sub ? {1'b0, big_ext - small_aligned}
	: {1'b0, big_ext} + {1'b0, small_aligned};

always_comb
begin
	lz = 4'(EXT_W);
	for (int i = 0; i < EXT_W; i++)
	begin
		if (raw[i])
		begin
			lz = 4'(EXT_W - 1 - i);
		end
	end

	shift_limit = big_exp_eff - 1'b1;
	left_shift = '0;

	if (raw[EXT_W])
	begin
		// carry out shifts right and keeps the sticky
		norm = {raw[EXT_W : 2], raw[1] | raw[0]};
		exp_norm = {1'b0, big_exp_eff} + 1'b1;
	end
	else
	begin
		// left shift stops at the subnormal boundary
		if ({1'b0, lz} > shift_limit)
		begin
			left_shift = shift_limit[3:0];
		end
		else
		begin
			left_shift = lz;
		end
		norm = raw[EXT_W - 1 : 0] << left_shift;
		exp_norm = {1'b0, big_exp_eff} - {2'b00, left_shift};
		// no hidden bit left, so the result is subnormal
		if (!norm[EXT_W - 1])
		begin
			exp_norm = '0;
		end
	end
end

// rounding decision on guard, round and sticky
assign inexact = |norm[`GRS_W - 1 : 0];

always_comb
begin
	case (rounding_mode)
		ROUND_NEAREST_EVEN:
		begin
			// ties go to the even neighbour
			round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
		end
		ROUND_INF:
		begin
			round_up = ~big.sign & inexact;
		end
		ROUND_INFN:
		begin
			round_up = big.sign & inexact;
		end
		default:
		begin
			round_up = 1'b0;
		end
	endcase
end

// a fraction carry walks into the exponent on its own
assign rounded = {exp_norm, norm[EXT_W - 2 : `GRS_W]} + `FLOAT_W'(round_up);
assign range_ovf = rounded[`FLOAT_W - 1 : `FRAC_W] >= {1'b0, {`EXP_W{1'b1}}};

// directed rounding away from infinity stops at the largest finite value
assign clamp = (rounding_mode == ROUND_ZERO)
	| ((rounding_mode == ROUND_INF) & big.sign)
	| ((rounding_mode == ROUND_INFN) & ~big.sign);

always_comb
begin
	overflow = 1'b0;
	if (a_nan | b_nan | (a_inf & b_inf & (a.sign != b.sign)))
	begin
		sum = `FLOAT_QNAN;
	end
	else if (a_inf)
	begin
		sum = a.sign ? `FLOAT_NEG_INF : `FLOAT_POS_INF;
	end
	else if (b_inf)
	begin
		sum = b.sign ? `FLOAT_NEG_INF : `FLOAT_POS_INF;
	end
	else if (raw == '0)
	begin
		// exact cancellation is +0 except when rounding down
		if (eff_sub)
		begin
			sum = (rounding_mode == ROUND_INFN) ? `FLOAT_NEG_ZERO : `FLOAT_POS_ZERO;
		end
		else
		begin
			sum = big.sign ? `FLOAT_NEG_ZERO : `FLOAT_POS_ZERO;
		end
	end
	else if (range_ovf)
	begin
		overflow = 1'b1;
		if (clamp)
		begin
			sum = {big.sign, `FLOAT_MAX_MAG};
		end
		else
		begin
			sum = big.sign ? `FLOAT_NEG_INF : `FLOAT_POS_INF;
		end
	end
	else
	begin
		sum = {big.sign, rounded[`EXP_W + `FRAC_W - 1 : 0]};
	end
end

// only the canonical quiet NaN ever leaves the adder
always_comb
begin
	if (!$isunknown(sum) && (sum.exponent == '1) && (sum.fraction != '0))
	begin
		assert (sum == `FLOAT_QNAN)
		else $error("adder produced a non-canonical NaN %h", sum);
	end
end

endmodule

/* fpu_types_pkg.sv */
`include "fpu_defines.svh"

package fpu_types_pkg;

	// sign, biased exponent, fraction
	typedef struct packed
	{
		logic sign;
		logic [`EXP_W - 1 : 0] exponent;
		logic [`FRAC_W - 1 : 0] fraction;
	} half_float_t;

	typedef enum logic [1:0]
	{
		ROUND_NEAREST_EVEN,
		ROUND_INF,
		ROUND_INFN,
		ROUND_ZERO
	} fpu_rounding_mode_t;

	typedef enum logic [1:0]
	{
		OP_ADD,
		OP_SUB,
		OP_NEG_ADD
	} fpu_op_t;

	typedef struct packed
	{
		half_float_t a;
		half_float_t b;
		fpu_op_t op;
		fpu_rounding_mode_t rounding_mode;
	} fpu_req_t;

	typedef struct packed
	{
		logic invalid;
		logic overflow;
		logic zero;
	} fpu_flags_t;

	typedef struct packed
	{
		half_float_t value;
		fpu_flags_t flags;
	} fpu_result_t;

endpackage

/* fpu_defines.svh */
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// half precision field widths
`define FLOAT_W 16
`define EXP_W 5
`define FRAC_W 10

// significand with hidden bit, plus guard, round and sticky
`define MANT_W (`FRAC_W + 1)
`define GRS_W 3

// sign bit position in the packed word
`define SIGN_POS (`FLOAT_W - 1)

// canonical encodings
`define FLOAT_POS_INF 16'h7c00
`define FLOAT_NEG_INF 16'hfc00
`define FLOAT_QNAN 16'h7e00
`define FLOAT_POS_ZERO 16'h0000
`define FLOAT_NEG_ZERO 16'h8000

// largest finite magnitude, sign bit excluded
`define FLOAT_MAX_MAG 15'h7bff

`endif
